//--- common/usb_demo_params.svh
`ifndef USB_DEMO_PARAMS_SVH
`define USB_DEMO_PARAMS_SVH

// Loopback FIFO address width, 2048 entries
`define USB_DEMO_FIFO_ABITS 11

// Reset stretch counter width, 16 cycles
`define USB_DEMO_RST_CYCLES_LOG2 4

// SOF counter bit shown on the heartbeat LED
`define USB_DEMO_HEARTBEAT_BIT 12

`endif

//--- common/usb_demo_pkg.sv
`default_nettype none

package usb_demo_pkg;

  // One byte of a bulk stream, last marks the end of a packet
  typedef struct packed {
    logic       last;
    logic [7:0] data;
  } stream_beat_t;

  // Status inputs from the USB device core, sampled every cycle
  typedef struct packed {
    // Start-of-frame level
    logic sof;
    // Single-cycle pulse
    logic crc_err;
    // Single-cycle pulse
    logic ctl_err;
    // Bus idle level
    logic idle;
  } status_evt_t;

endpackage

`default_nettype wire

//--- logic/reset_stretch.sv
`timescale 1ns/10ps
`default_nettype none
`include "usb_demo_params.svh"

module reset_stretch (
  input  wire  usb_clock_i,
  input  wire  rst_n,
  output logic fabric_reset_o
);

  // One spare bit on top, which ends the count
  localparam int CNT_W = `USB_DEMO_RST_CYCLES_LOG2 + 1;

  logic [CNT_W-1:0] cnt_q;

  // Saturates once the top bit is set
  always_ff @(posedge usb_clock_i or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!cnt_q[CNT_W-1]) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Asserted with rst_n, released on the clock edge that sets the top bit
  assign fabric_reset_o = ~cnt_q[CNT_W-1];

endmodule

`default_nettype wire

//--- loopback/axis_sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none
`include "usb_demo_params.svh"

module axis_sync_fifo #(
  parameter int  ABITS     = `USB_DEMO_FIFO_ABITS,
  parameter type payload_t = logic [7:0]
) (
  input  wire           usb_clock_i,
  input  wire           rst_n,
  input  wire           reset_i,
  input  wire           push_valid_i,
  output logic          push_ready_o,
  input  wire payload_t push_data_i,
  input  wire           pop_i,
  output logic          out_valid_o,
  output payload_t      out_data_o,
  output logic          full_o
);

  localparam int DEPTH = 1 << ABITS;
  localparam logic [ABITS:0] LEVEL_FULL = (ABITS + 1)'(DEPTH);

  payload_t mem [DEPTH];

  // Pointers carry one wrap bit
  logic [ABITS:0] wr_ptr_q;
  logic [ABITS:0] rd_ptr_q;
  // Write pointer as seen by the read side, one cycle late
  logic [ABITS:0] wr_ptr_seen_q;

  // Entries held in memory plus the output register
  logic [ABITS:0] level_q;
  logic [ABITS:0] level_d;

  logic     ready_q;
  logic     out_valid_q;
  payload_t out_data_q;

  logic push_fire;
  logic pop_fire;
  logic fetch;

  assign push_fire = push_valid_i && ready_q;
  assign pop_fire  = pop_i && out_valid_q;

  // Refill the output register when it is empty or being emptied
  assign fetch = (rd_ptr_q != wr_ptr_seen_q) && (!out_valid_q || pop_fire);

  always_comb begin
    level_d = level_q;
    if (push_fire && !pop_fire) begin
      level_d = level_q + 1'b1;
    end else if (pop_fire && !push_fire) begin
      level_d = level_q - 1'b1;
    end
  end

  always_ff @(posedge usb_clock_i) begin
    if (push_fire) begin
      mem[wr_ptr_q[ABITS-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge usb_clock_i) begin
    if (fetch) begin
      out_data_q <= mem[rd_ptr_q[ABITS-1:0]];
    end
  end

  always_ff @(posedge usb_clock_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q      <= '0;
      wr_ptr_seen_q <= '0;
      rd_ptr_q      <= '0;
      level_q       <= '0;
      ready_q       <= 1'b0;
      out_valid_q   <= 1'b0;
    end else if (reset_i) begin
      wr_ptr_q      <= '0;
      wr_ptr_seen_q <= '0;
      rd_ptr_q      <= '0;
      level_q       <= '0;
      ready_q       <= 1'b0;
      out_valid_q   <= 1'b0;
    end else begin
      wr_ptr_seen_q <= wr_ptr_q;
      level_q       <= level_d;
      // Registered ready, low once the next level reaches capacity
      ready_q       <= (level_d != LEVEL_FULL);
      if (push_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (fetch) begin
        rd_ptr_q    <= rd_ptr_q + 1'b1;
        out_valid_q <= 1'b1;
      end else if (pop_fire) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  assign push_ready_o = ready_q;
  assign out_valid_o  = out_valid_q;
  assign out_data_o   = out_data_q;
  assign full_o       = (level_q == LEVEL_FULL);

endmodule

`default_nettype wire

//--- loopback/packet_gate.sv
`timescale 1ns/10ps
`default_nettype none
`include "usb_demo_params.svh"

module packet_gate (
  input  wire                             usb_clock_i,
  input  wire                             rst_n,
  input  wire                             reset_i,
  input  wire                             wr_fire_i,
  input  wire                             wr_last_i,
  input  wire                             fifo_valid_i,
  input  wire usb_demo_pkg::stream_beat_t fifo_beat_i,
  input  wire                             fifo_full_i,
  input  wire                             m_ready_i,
  output logic                            m_valid_o,
  output usb_demo_pkg::stream_beat_t      m_beat_o,
  output logic                            pop_o
);

  // Sized for the default FIFO depth, every packet holds at least one byte
  localparam int CNT_W = `USB_DEMO_FIFO_ABITS + 1;

  logic [CNT_W-1:0] pkt_cnt_q;
  logic             pkt_in;
  logic             pkt_out;
  logic             release_rd;

  assign pkt_in  = wr_fire_i && wr_last_i;
  assign pkt_out = pop_o && fifo_beat_i.last;

  // A full FIFO also releases, so oversized packets still drain
  assign release_rd = (pkt_cnt_q != '0) || fifo_full_i;

  always_ff @(posedge usb_clock_i or negedge rst_n) begin
    if (!rst_n) begin
      pkt_cnt_q <= '0;
    end else if (reset_i) begin
      pkt_cnt_q <= '0;
    end else if (pkt_in && !pkt_out) begin
      pkt_cnt_q <= pkt_cnt_q + 1'b1;
    end else if (pkt_out && !pkt_in) begin
      pkt_cnt_q <= pkt_cnt_q - 1'b1;
    end
  end

  assign m_valid_o = fifo_valid_i && release_rd;
  assign m_beat_o  = fifo_beat_i;

  // One pop per output transfer
  assign pop_o = m_valid_o && m_ready_i;

endmodule

`default_nettype wire

//--- logic/status_leds.sv
`timescale 1ns/10ps
`default_nettype none
`include "usb_demo_params.svh"

module status_leds #(
  parameter int HEARTBEAT_BIT = `USB_DEMO_HEARTBEAT_BIT
) (
  input  wire                            usb_clock_i,
  input  wire                            rst_n,
  input  wire                            reset_i,
  input  wire usb_demo_pkg::status_evt_t evt_i,
  output logic [3:0]                     leds_o
);

  usb_demo_pkg::status_evt_t evt_q;

  logic                   sof_prev_q;
  logic [HEARTBEAT_BIT:0] sof_cnt_q;
  logic                   ctl_err_q;
  logic                   crc_err_q;
  logic                   idle_q;
  logic                   sof_rise;

  assign sof_rise = evt_q.sof && !sof_prev_q;

  // Input stage samples the core status every cycle
  always_ff @(posedge usb_clock_i or negedge rst_n) begin
    if (!rst_n) begin
      evt_q <= '0;
    end else if (reset_i) begin
      evt_q <= '0;
    end else begin
      evt_q <= evt_i;
    end
  end

  // LED state, updated one cycle after sampling
  always_ff @(posedge usb_clock_i or negedge rst_n) begin
    if (!rst_n) begin
      sof_prev_q <= 1'b0;
      sof_cnt_q  <= '0;
      ctl_err_q  <= 1'b0;
      crc_err_q  <= 1'b0;
      idle_q     <= 1'b0;
    end else if (reset_i) begin
      sof_prev_q <= 1'b0;
      sof_cnt_q  <= '0;
      ctl_err_q  <= 1'b0;
      crc_err_q  <= 1'b0;
      idle_q     <= 1'b0;
    end else begin
      sof_prev_q <= evt_q.sof;
      idle_q     <= evt_q.idle;
      if (sof_rise) begin
        sof_cnt_q <= sof_cnt_q + 1'b1;
      end
      // Sticky until the next reset
      if (evt_q.ctl_err) begin
        ctl_err_q <= 1'b1;
      end
      if (evt_q.crc_err) begin
        crc_err_q <= 1'b1;
      end
    end
  end

  // Active low drive
  assign leds_o = ~{sof_cnt_q[HEARTBEAT_BIT], ctl_err_q, crc_err_q, idle_q};

endmodule

`default_nettype wire

//--- logic/usb_loopback_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "usb_demo_params.svh"

module usb_loopback_top #(
  parameter int FIFO_ABITS    = `USB_DEMO_FIFO_ABITS,
  parameter int HEARTBEAT_BIT = `USB_DEMO_HEARTBEAT_BIT
) (
  input  wire                             usb_clock_i,
  input  wire                             rst_n,

  // Bytes received from the host
  input  wire                             s_valid_i,
  input  wire usb_demo_pkg::stream_beat_t s_beat_i,
  output logic                            s_ready_o,

  // Bytes returned to the host
  output logic                            m_valid_o,
  output usb_demo_pkg::stream_beat_t      m_beat_o,
  input  wire                             m_ready_i,

  input  wire usb_demo_pkg::status_evt_t  evt_i,
  output logic [3:0]                      leds_o
);

  logic                       fabric_reset;
  logic                       wr_fire;
  logic                       fifo_valid;
  logic                       fifo_full;
  logic                       fifo_pop;
  usb_demo_pkg::stream_beat_t fifo_beat;

  reset_stretch u_reset_stretch (
    .usb_clock_i    (usb_clock_i),
    .rst_n          (rst_n),
    .fabric_reset_o (fabric_reset)
  );

  // Write side transfer, seen by the packet counter
  assign wr_fire = s_valid_i && s_ready_o;

  axis_sync_fifo #(
    .ABITS     (FIFO_ABITS),
    .payload_t (usb_demo_pkg::stream_beat_t)
  ) u_fifo (
    .usb_clock_i  (usb_clock_i),
    .rst_n        (rst_n),
    .reset_i      (fabric_reset),
    .push_valid_i (s_valid_i),
    .push_ready_o (s_ready_o),
    .push_data_i  (s_beat_i),
    .pop_i        (fifo_pop),
    .out_valid_o  (fifo_valid),
    .out_data_o   (fifo_beat),
    .full_o       (fifo_full)
  );

  packet_gate u_packet_gate (
    .usb_clock_i  (usb_clock_i),
    .rst_n        (rst_n),
    .reset_i      (fabric_reset),
    .wr_fire_i    (wr_fire),
    .wr_last_i    (s_beat_i.last),
    .fifo_valid_i (fifo_valid),
    .fifo_beat_i  (fifo_beat),
    .fifo_full_i  (fifo_full),
    .m_ready_i    (m_ready_i),
    .m_valid_o    (m_valid_o),
    .m_beat_o     (m_beat_o),
    .pop_o        (fifo_pop)
  );

  status_leds #(
    .HEARTBEAT_BIT (HEARTBEAT_BIT)
  ) u_status_leds (
    .usb_clock_i (usb_clock_i),
    .rst_n       (rst_n),
    .reset_i     (fabric_reset),
    .evt_i       (evt_i),
    .leds_o      (leds_o)
  );

endmodule

`default_nettype wire

//--- tb/tb_usb_loopback.sv
`timescale 1ns/10ps
`default_nettype none

module tb_usb_loopback;

  localparam int TIMEOUT   = 4000;
  localparam int FIFO_SIZE = 16;
  localparam int N_PKTS    = 40;

  logic                       usb_clock;
  logic                       rst_n;
  logic                       s_valid;
  usb_demo_pkg::stream_beat_t s_beat;
  logic                       s_ready;
  logic                       m_valid;
  usb_demo_pkg::stream_beat_t m_beat;
  logic                       m_ready;
  usb_demo_pkg::status_evt_t  evt;
  logic [3:0]                 leds;

  // Scoreboard of accepted beats not yet returned
  usb_demo_pkg::stream_beat_t sb_q[$];
  int    pending_last  = 0;
  int    beats_sent    = 0;
  int    beats_checked = 0;
  string test_name     = "reset";

  int   seed       = 50808;
  // 0 holds m_ready low, 1 holds it high, 2 plays the random pattern
  int   ready_mode = 0;
  int   ready_idx  = 0;
  logic ready_pat [1024];

  usb_loopback_top #(
    .FIFO_ABITS    (4),
    .HEARTBEAT_BIT (2)
  ) u_dut (
    .usb_clock_i (usb_clock),
    .rst_n       (rst_n),
    .s_valid_i   (s_valid),
    .s_beat_i    (s_beat),
    .s_ready_o   (s_ready),
    .m_valid_o   (m_valid),
    .m_beat_o    (m_beat),
    .m_ready_i   (m_ready),
    .evt_i       (evt),
    .leds_o      (leds)
  );

  initial usb_clock = 1'b0;
  always #5 usb_clock = ~usb_clock;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first failed check");
  endtask

  function automatic string beat_text(input usb_demo_pkg::stream_beat_t b);
    return $sformatf("data=%02h last=%0b", b.data, b.last);
  endfunction

  // Core model of the output side
  always @(negedge usb_clock) begin
    if (ready_mode == 2) begin
      m_ready   = ready_pat[ready_idx];
      ready_idx = (ready_idx + 1) % 1024;
    end else begin
      m_ready = (ready_mode == 1);
    end
  end

  // Values seen here are the ones before the edge
  always @(posedge usb_clock) begin
    usb_demo_pkg::stream_beat_t exp_beat;
    if (!rst_n) begin
      sb_q.delete();
      pending_last = 0;
    end else begin
      assert (!m_valid || pending_last > 0 || sb_q.size() >= FIFO_SIZE)
        else stop_with_failure("m_valid_o high with no whole packet stored and the FIFO not full");
      assert (!s_ready || sb_q.size() < FIFO_SIZE)
        else stop_with_failure("s_ready_o high while the FIFO already holds 16 beats");
      if (m_valid && m_ready) begin
        assert (sb_q.size() > 0)
          else stop_with_failure("output transfer while no beat was expected");
        exp_beat = sb_q.pop_front();
        assert (m_beat == exp_beat)
          else stop_with_failure($sformatf("Mismatch %s: expected %s actual %s",
                                           test_name, beat_text(exp_beat), beat_text(m_beat)));
        if (exp_beat.last) begin
          pending_last--;
        end
        beats_checked++;
      end
      if (s_valid && s_ready) begin
        sb_q.push_back(s_beat);
        if (s_beat.last) begin
          pending_last++;
        end
        beats_sent++;
      end
    end
  end

  // An offered output beat holds until it is taken
  a_out_hold: assert property (@(posedge usb_clock) disable iff (!rst_n)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
    else stop_with_failure("output beat changed or vanished while m_ready_i was low");

  a_reset_quiet: assert property (@(posedge usb_clock)
    !rst_n |-> (!m_valid && !s_ready && leds[3:1] == 3'b111))
    else stop_with_failure("outputs or LEDs active while rst_n was low");

  // Called at time zero or on a falling edge
  task automatic apply_reset();
    int waited;
    waited  = 0;
    rst_n   = 1'b0;
    s_valid = 1'b0;
    evt     = '0;
    repeat (2) begin
      @(negedge usb_clock);
    end
    rst_n = 1'b1;
    while (!s_ready) begin
      assert (!m_valid && leds[3:1] == 3'b111)
        else stop_with_failure("m_valid_o high or an LED on before s_ready_o rose");
      @(negedge usb_clock);
      waited++;
      if (waited > 20) begin
        stop_with_failure("s_ready_o did not rise within 20 cycles of reset release");
      end
    end
  endtask

  // Starts and ends on a falling edge and leaves valid high
  task automatic send_beat(input logic [7:0] data, input logic last);
    int waited;
    waited = 0;
    s_valid     = 1'b1;
    s_beat.data = data;
    s_beat.last = last;
    while (!s_ready) begin
      @(negedge usb_clock);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("%s: s_ready_o stayed low for %0d cycles",
                                    test_name, TIMEOUT));
      end
    end
    @(negedge usb_clock);
  endtask

  task automatic send_random_packet(input int len);
    int rnd;
    for (int i = 0; i < len; i++) begin
      rnd = $random(seed);
      send_beat(rnd[7:0], (i == len - 1));
    end
    s_valid = 1'b0;
  endtask

  task automatic wait_out_valid();
    int waited;
    waited = 0;
    while (!m_valid) begin
      @(negedge usb_clock);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("%s: m_valid_o never rose after the packet end", test_name));
      end
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 || m_valid) begin
      @(negedge usb_clock);
      waited++;
      if (waited > TIMEOUT) begin
        stop_with_failure($sformatf("%s: FIFO did not drain within %0d cycles",
                                    test_name, TIMEOUT));
      end
    end
  endtask

  task automatic check_led(input int idx, input logic expected);
    assert (leds[idx] == expected)
      else stop_with_failure($sformatf("Mismatch %s: expected led%0d=%0b actual %0b",
                                       test_name, idx, expected, leds[idx]));
  endtask

  initial begin
    int rnd;
    int len;
    logic [7:0] held_data;
    rst_n       = 1'b0;
    s_valid     = 1'b0;
    s_beat      = '0;
    m_ready     = 1'b0;
    evt         = '0;
    for (int i = 0; i < 1024; i++) begin
      rnd          = $random(seed);
      ready_pat[i] = rnd[0];
    end

    apply_reset();

    test_name  = "single_packet";
    ready_mode = 1;
    send_random_packet(5);
    wait_drained();

    // Gate stays shut while a packet is held open
    test_name = "packet_gate";
    for (int i = 0; i < 5; i++) begin
      rnd = $random(seed);
      send_beat(rnd[7:0], 1'b0);
    end
    s_valid = 1'b0;
    repeat (12) begin
      @(negedge usb_clock);
      assert (!m_valid)
        else stop_with_failure("m_valid_o rose before the last beat of the packet was accepted");
    end
    send_random_packet(3);
    wait_out_valid();
    wait_drained();

    test_name  = "random_order";
    ready_mode = 2;
    for (int p = 0; p < N_PKTS; p++) begin
      len = 1 + ($unsigned($random(seed)) % 12);
      send_random_packet(len);
      rnd = $random(seed);
      repeat (rnd[1:0]) begin
        @(negedge usb_clock);
      end
    end
    wait_drained();

    // Oversized packet against a stalled output
    test_name  = "full_fifo";
    ready_mode = 0;
    repeat (2) begin
      @(negedge usb_clock);
    end
    for (int i = 0; i < FIFO_SIZE; i++) begin
      rnd = $random(seed);
      send_beat(rnd[7:0], 1'b0);
    end
    rnd       = $random(seed);
    held_data = rnd[7:0];
    s_beat.data = held_data;
    repeat (8) begin
      assert (!s_ready && m_valid)
        else stop_with_failure("full FIFO did not drop s_ready_o or did not release its head");
      @(negedge usb_clock);
    end
    ready_mode = 1;
    send_beat(held_data, 1'b0);
    send_random_packet(3);
    wait_drained();

    test_name = "heartbeat";
    for (int k = 1; k <= 13; k++) begin
      evt.sof = 1'b1;
      // Longer pulses still count once
      repeat (1 + (k % 2)) begin
        @(negedge usb_clock);
      end
      evt.sof = 1'b0;
      repeat (2) begin
        @(negedge usb_clock);
      end
      check_led(3, ~k[2]);
    end

    test_name   = "crc_err";
    evt.crc_err = 1'b1;
    @(negedge usb_clock);
    evt.crc_err = 1'b0;
    check_led(1, 1'b1);
    @(negedge usb_clock);
    check_led(1, 1'b0);
    check_led(2, 1'b1);

    test_name   = "ctl_err";
    evt.ctl_err = 1'b1;
    @(negedge usb_clock);
    evt.ctl_err = 1'b0;
    check_led(2, 1'b1);
    @(negedge usb_clock);
    repeat (10) begin
      check_led(2, 1'b0);
      check_led(1, 1'b0);
      @(negedge usb_clock);
    end

    test_name = "idle";
    evt.idle  = 1'b1;
    repeat (2) begin
      @(negedge usb_clock);
    end
    check_led(0, 1'b0);
    evt.idle = 1'b0;
    repeat (2) begin
      @(negedge usb_clock);
    end
    check_led(0, 1'b1);

    // Sticky LEDs and heartbeat clear only on reset
    test_name = "reset_again";
    apply_reset();
    check_led(2, 1'b1);
    check_led(1, 1'b1);

    if (beats_sent > 0 && beats_checked == beats_sent) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure($sformatf("accepted %0d beats but %0d came back",
                                  beats_sent, beats_checked));
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/usb_demo_pkg.sv
logic/reset_stretch.sv
loopback/axis_sync_fifo.sv
loopback/packet_gate.sv
logic/status_leds.sv
logic/usb_loopback_top.sv
tb/tb_usb_loopback.sv

//--- Makefile
# Verilator build and run of the USB loopback testbench
SIM := obj_dir/Vtb_usb_loopback
SRC := $(filter %.sv,$(shell cat verilog.f)) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): verilog.f $(SRC)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module tb_usb_loopback -Mdir obj_dir -f verilog.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
